/* filelist.f */
source/frontend_pkg.sv
source/axil_if.sv
source/fetch_pair_if.sv
source/instr_mem.sv
source/fetch_unit.sv
source/branch_predictor.sv
source/frontend_top.sv
verification/frontend_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the front end testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
    -f filelist.f --top-module frontend_tb -o frontend_sim; then
  echo "verilator build failed"
  exit 1
fi

output="$(./obj_dir/frontend_sim)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* source/axil_if.sv */
`default_nettype none

interface axil_if;
  import frontend_pkg::*;

  // write address and data
  xlen_t awaddr;
  logic awvalid;
  logic awready;
  xlen_t wdata;
  logic [AXIL_STRB_BITS-1:0] wstrb;
  logic wvalid;
  logic wready;
  // write response
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  // read address and data
  xlen_t araddr;
  logic arvalid;
  logic arready;
  xlen_t rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;

  modport manager (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

  modport subordinate (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

endinterface

`default_nettype wire

/* source/branch_predictor.sv */
`default_nettype none

module branch_predictor (
  input  wire                                     clk,
  input  wire                                     rst,
  fetch_pair_if.consumer                          pair,
  input  wire                                     resolve_valid_i,
  input  wire                                     resolve_taken_i,
  output frontend_pkg::pc_t                       next_pc_o,
  output logic [frontend_pkg::DISPATCH_WIDTH-1:0] slot_valid_o,
  output logic                                    speculative_o
);

  import frontend_pkg::*;

  typedef enum logic [1:0] {
    STRONG_NOT_TAKEN,
    WEAK_NOT_TAKEN,
    WEAK_TAKEN,
    STRONG_TAKEN
  } counter_t;

  counter_t counter_q;
  logic speculative_q;

  pc_t slot_pc [DISPATCH_WIDTH];
  instr_t slot_instr [DISPATCH_WIDTH];
  ctrl_kind_t kind [DISPATCH_WIDTH];
  logic [DISPATCH_WIDTH-1:0] is_ctrl;
  xlen_t imm_b [DISPATCH_WIDTH];
  xlen_t imm_j [DISPATCH_WIDTH];
  pc_t target [DISPATCH_WIDTH];

  ctrl_kind_t sel_kind;
  pc_t sel_target;
  logic pred_taken;
  pc_t seq_pc;
  logic valid_ctrl;

  function automatic ctrl_kind_t classify(input instr_t instr);
    case (instr[6:0])
      OPC_BRANCH: classify = CTRL_BRANCH;
      OPC_JAL:    classify = CTRL_JAL;
      OPC_JALR:   classify = CTRL_JALR;
      default:    classify = CTRL_NONE;
    endcase
  endfunction

  // per-slot decode and target
  always_comb begin
    slot_pc[0] = pair.pc0;
    slot_pc[1] = pair.pc1;
    slot_instr[0] = pair.instr0;
    slot_instr[1] = pair.instr1;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      kind[i] = classify(slot_instr[i]);
      is_ctrl[i] = (kind[i] != CTRL_NONE);
      imm_b[i] = {{19{slot_instr[i][31]}}, slot_instr[i][31], slot_instr[i][7],
                  slot_instr[i][30:25], slot_instr[i][11:8], 1'b0};
      imm_j[i] = {{11{slot_instr[i][31]}}, slot_instr[i][31], slot_instr[i][19:12],
                  slot_instr[i][20], slot_instr[i][30:21], 1'b0};
      if (kind[i] == CTRL_JAL) begin
        target[i] = slot_pc[i] + imm_j[i];
      end else begin
        target[i] = slot_pc[i] + imm_b[i];
      end
    end
  end

  // first control instruction in slot order wins
  always_comb begin
    if (is_ctrl[0]) begin
      sel_kind = kind[0];
      sel_target = target[0];
    end else begin
      sel_kind = kind[1];
      sel_target = target[1];
    end
    pred_taken = (sel_kind == CTRL_JAL) ||
                 ((sel_kind == CTRL_BRANCH) && (counter_q inside {WEAK_TAKEN, STRONG_TAKEN}));
    seq_pc = pair.pc0 + pc_t'(DISPATCH_WIDTH * INSTR_BYTES);
  end

  always_comb begin
    if (!speculative_q) begin
      slot_valid_o[0] = pair.pair_valid;
      slot_valid_o[1] = pair.pair_valid && !(is_ctrl[0] && (pred_taken || is_ctrl[1]));
      if (pred_taken) begin
        next_pc_o = sel_target;
      end else if (is_ctrl[0] && is_ctrl[1]) begin
        // second control gets refetched as the new slot0
        next_pc_o = pair.pc1;
      end else begin
        next_pc_o = seq_pc;
      end
    end else begin
      // stall at the next control until the outstanding one resolves
      slot_valid_o[0] = pair.pair_valid && !is_ctrl[0];
      slot_valid_o[1] = pair.pair_valid && !is_ctrl[0] && !is_ctrl[1];
      if (is_ctrl[0]) begin
        next_pc_o = pair.pc0;
      end else if (is_ctrl[1]) begin
        next_pc_o = pair.pc1;
      end else begin
        next_pc_o = seq_pc;
      end
    end
  end

  assign valid_ctrl = |(is_ctrl & slot_valid_o);
  assign speculative_o = speculative_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      speculative_q <= 1'b0;
    end else if (resolve_valid_i) begin
      speculative_q <= 1'b0;
    end else if (pair.fire && valid_ctrl) begin
      speculative_q <= 1'b1;
    end
  end

  // 2-bit saturating counter, shared by all branches
  always_ff @(posedge clk) begin
    if (rst) begin
      counter_q <= WEAK_NOT_TAKEN;
    end else if (resolve_valid_i) begin
      case (counter_q)
        STRONG_NOT_TAKEN: counter_q <= resolve_taken_i ? WEAK_NOT_TAKEN : STRONG_NOT_TAKEN;
        WEAK_NOT_TAKEN:   counter_q <= resolve_taken_i ? WEAK_TAKEN : STRONG_NOT_TAKEN;
        WEAK_TAKEN:       counter_q <= resolve_taken_i ? STRONG_TAKEN : WEAK_NOT_TAKEN;
        default:          counter_q <= resolve_taken_i ? STRONG_TAKEN : WEAK_TAKEN;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/fetch_pair_if.sv */
`default_nettype none

interface fetch_pair_if;
  import frontend_pkg::*;

  pc_t pc0;
  pc_t pc1;
  instr_t instr0;
  instr_t instr1;
  // pair on offer, and pair taken by the back end
  logic pair_valid;
  logic fire;

  modport producer (
    output pc0, pc1, instr0, instr1, pair_valid, fire
  );

  modport consumer (
    input pc0, pc1, instr0, instr1, pair_valid, fire
  );

endinterface

`default_nettype wire

/* source/fetch_unit.sv */
`default_nettype none

module fetch_unit (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      fetch_enable_i,
  input  wire                      dispatch_ready_i,
  input  frontend_pkg::pc_t        next_pc_i,
  output frontend_pkg::imem_addr_t rd_addr0_o,
  output frontend_pkg::imem_addr_t rd_addr1_o,
  input  frontend_pkg::instr_t     rd_data0_i,
  input  frontend_pkg::instr_t     rd_data1_i,
  fetch_pair_if.producer           pair
);

  import frontend_pkg::*;

  pc_t pc_q;
  pc_t pc1;
  imem_addr_t word0;
  logic fire;

  assign pc1 = pc_q + pc_t'(INSTR_BYTES);

  // word indices, second one wraps at the end of memory
  assign word0 = pc_q[2 +: IMEM_ADDR_BITS];
  assign rd_addr0_o = word0;
  assign rd_addr1_o = word0 + imem_addr_t'(1);

  assign fire = fetch_enable_i && dispatch_ready_i;

  assign pair.pc0 = pc_q;
  assign pair.pc1 = pc1;
  assign pair.instr0 = rd_data0_i;
  assign pair.instr1 = rd_data1_i;
  assign pair.pair_valid = fetch_enable_i;
  assign pair.fire = fire;

  // pc only moves when the back end takes the pair
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else if (fire) begin
      pc_q <= next_pc_i;
    end
  end

endmodule

`default_nettype wire

/* source/frontend_pkg.sv */
`default_nettype none

package frontend_pkg;

  // slots fetched and dispatched per cycle
  localparam int unsigned DISPATCH_WIDTH = 2;
  localparam int unsigned INSTR_BYTES = 4;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] pc_t;
  typedef logic [31:0] instr_t;

  // instruction memory geometry
  localparam int unsigned IMEM_WORDS = 256;
  localparam int unsigned IMEM_ADDR_BITS = $clog2(IMEM_WORDS);

  typedef logic [IMEM_ADDR_BITS-1:0] imem_addr_t;

  localparam pc_t RESET_PC = 32'h0000_0000;

  // axi4-lite side
  localparam int unsigned AXIL_STRB_BITS = 4;
  localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

  // major opcodes of the control instructions
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_JAL = 7'b110_1111;
  localparam logic [6:0] OPC_JALR = 7'b110_0111;

  typedef enum logic [1:0] {
    CTRL_NONE,
    CTRL_BRANCH,
    CTRL_JAL,
    CTRL_JALR
  } ctrl_kind_t;

endpackage

`default_nettype wire

/* source/frontend_top.sv */
`default_nettype none

module frontend_top (
  input  wire                                     clk,
  input  wire                                     rst,
  input  wire                                     fetch_enable_i,
  // axi4-lite load port
  input  frontend_pkg::xlen_t                     s_axil_awaddr_i,
  input  wire                                     s_axil_awvalid_i,
  output logic                                    s_axil_awready_o,
  input  frontend_pkg::xlen_t                     s_axil_wdata_i,
  input  wire [frontend_pkg::AXIL_STRB_BITS-1:0]  s_axil_wstrb_i,
  input  wire                                     s_axil_wvalid_i,
  output logic                                    s_axil_wready_o,
  output logic [1:0]                              s_axil_bresp_o,
  output logic                                    s_axil_bvalid_o,
  input  wire                                     s_axil_bready_i,
  input  frontend_pkg::xlen_t                     s_axil_araddr_i,
  input  wire                                     s_axil_arvalid_i,
  output logic                                    s_axil_arready_o,
  output frontend_pkg::xlen_t                     s_axil_rdata_o,
  output logic [1:0]                              s_axil_rresp_o,
  output logic                                    s_axil_rvalid_o,
  input  wire                                     s_axil_rready_i,
  // dispatch port
  output logic                                    dispatch_valid_o,
  input  wire                                     dispatch_ready_i,
  output frontend_pkg::pc_t                       dispatch_pc0_o,
  output frontend_pkg::pc_t                       dispatch_pc1_o,
  output frontend_pkg::instr_t                    dispatch_instr0_o,
  output frontend_pkg::instr_t                    dispatch_instr1_o,
  output logic [frontend_pkg::DISPATCH_WIDTH-1:0] dispatch_slot_valid_o,
  // resolution from the back end
  input  wire                                     resolve_valid_i,
  input  wire                                     resolve_taken_i,
  output logic                                    speculative_o
);

  import frontend_pkg::*;

  pc_t next_pc;
  imem_addr_t rd_addr0;
  imem_addr_t rd_addr1;
  instr_t rd_data0;
  instr_t rd_data1;

  axil_if i_axil ();
  fetch_pair_if i_pair ();

  assign i_axil.awaddr = s_axil_awaddr_i;
  assign i_axil.awvalid = s_axil_awvalid_i;
  assign i_axil.wdata = s_axil_wdata_i;
  assign i_axil.wstrb = s_axil_wstrb_i;
  assign i_axil.wvalid = s_axil_wvalid_i;
  assign i_axil.bready = s_axil_bready_i;
  assign i_axil.araddr = s_axil_araddr_i;
  assign i_axil.arvalid = s_axil_arvalid_i;
  assign i_axil.rready = s_axil_rready_i;
  assign s_axil_awready_o = i_axil.awready;
  assign s_axil_wready_o = i_axil.wready;
  assign s_axil_bresp_o = i_axil.bresp;
  assign s_axil_bvalid_o = i_axil.bvalid;
  assign s_axil_arready_o = i_axil.arready;
  assign s_axil_rdata_o = i_axil.rdata;
  assign s_axil_rresp_o = i_axil.rresp;
  assign s_axil_rvalid_o = i_axil.rvalid;

  assign dispatch_valid_o = i_pair.pair_valid;
  assign dispatch_pc0_o = i_pair.pc0;
  assign dispatch_pc1_o = i_pair.pc1;
  assign dispatch_instr0_o = i_pair.instr0;
  assign dispatch_instr1_o = i_pair.instr1;

  instr_mem i_instr_mem (
    .clk        (clk),
    .rst        (rst),
    .axil       (i_axil.subordinate),
    .rd_addr0_i (rd_addr0),
    .rd_addr1_i (rd_addr1),
    .rd_data0_o (rd_data0),
    .rd_data1_o (rd_data1)
  );

  fetch_unit i_fetch_unit (
    .clk              (clk),
    .rst              (rst),
    .fetch_enable_i   (fetch_enable_i),
    .dispatch_ready_i (dispatch_ready_i),
    .next_pc_i        (next_pc),
    .rd_addr0_o       (rd_addr0),
    .rd_addr1_o       (rd_addr1),
    .rd_data0_i       (rd_data0),
    .rd_data1_i       (rd_data1),
    .pair             (i_pair.producer)
  );

  branch_predictor i_branch_predictor (
    .clk             (clk),
    .rst             (rst),
    .pair            (i_pair.consumer),
    .resolve_valid_i (resolve_valid_i),
    .resolve_taken_i (resolve_taken_i),
    .next_pc_o       (next_pc),
    .slot_valid_o    (dispatch_slot_valid_o),
    .speculative_o   (speculative_o)
  );

endmodule

`default_nettype wire

/* source/instr_mem.sv */
`default_nettype none

module instr_mem (
  input  wire                     clk,
  input  wire                     rst,
  axil_if.subordinate             axil,
  input  frontend_pkg::imem_addr_t rd_addr0_i,
  input  frontend_pkg::imem_addr_t rd_addr1_i,
  output frontend_pkg::instr_t    rd_data0_o,
  output frontend_pkg::instr_t    rd_data1_o
);

  import frontend_pkg::*;

  instr_t mem [IMEM_WORDS];

  logic bvalid_q;
  logic rvalid_q;
  xlen_t rdata_q;
  logic wr_accept;
  logic rd_accept;
  imem_addr_t wr_idx;
  imem_addr_t rd_idx;

  // fetch side reads straight out of the array
  assign rd_data0_o = mem[rd_addr0_i];
  assign rd_data1_o = mem[rd_addr1_i];

  // byte address to word index
  assign wr_idx = axil.awaddr[2 +: IMEM_ADDR_BITS];
  assign rd_idx = axil.araddr[2 +: IMEM_ADDR_BITS];

  // address and data are taken together, one response at a time
  assign wr_accept = axil.awvalid && axil.wvalid && !bvalid_q;
  assign rd_accept = axil.arvalid && !rvalid_q;

  assign axil.awready = wr_accept;
  assign axil.wready = wr_accept;
  assign axil.bvalid = bvalid_q;
  assign axil.bresp = AXIL_RESP_OKAY;
  assign axil.arready = !rvalid_q;
  assign axil.rvalid = rvalid_q;
  assign axil.rdata = rdata_q;
  assign axil.rresp = AXIL_RESP_OKAY;

  // full-word writes only
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      mem[wr_idx] <= axil.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rdata_q <= mem[rd_idx];
    end
  end

  // response handshakes
  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_accept) begin
        bvalid_q <= 1'b1;
      end else if (axil.bready) begin
        bvalid_q <= 1'b0;
      end

      if (rd_accept) begin
        rvalid_q <= 1'b1;
      end else if (axil.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* verification/frontend_tb.sv */
`default_nettype none

module frontend_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import frontend_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 3;
  localparam int HANDSHAKE_LIMIT = 16;
  localparam int RUN_LEN = 300;
  localparam int AXI_WORDS = 32;
  // twice the expected length of all loads and runs
  localparam int WATCHDOG_CYCLES = 2 * (AXI_WORDS * 8 + 5 * (IMEM_WORDS * 4 + 8)
                                        + 6 * RUN_LEN + 64);

  typedef enum {PROG_STRAIGHT, PROG_BRANCHES, PROG_JUMPS, PROG_DENSE, PROG_PAIRS} prog_t;

  logic clk;
  logic rst;
  logic fetch_enable;
  xlen_t awaddr;
  logic awvalid;
  xlen_t wdata;
  logic wvalid;
  xlen_t araddr;
  logic arvalid;
  logic dispatch_ready;
  logic resolve_valid;
  logic resolve_taken;
  logic awready;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic arready;
  xlen_t rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic dispatch_valid;
  pc_t dispatch_pc0;
  pc_t dispatch_pc1;
  instr_t dispatch_instr0;
  instr_t dispatch_instr1;
  logic [DISPATCH_WIDTH-1:0] dispatch_slot_valid;
  logic speculative;

  // program image with the kind and byte offset of every word
  instr_t image [IMEM_WORDS];
  ctrl_kind_t img_kind [IMEM_WORDS];
  pc_t img_off [IMEM_WORDS];

  // reference predictor state where 0 is strong not-taken
  pc_t ref_pc;
  logic ref_spec;
  logic [1:0] ref_counter;

  imem_addr_t idx0;
  imem_addr_t idx1;
  logic ctrl0;
  logic ctrl1;
  ctrl_kind_t first_kind;
  pc_t first_target;
  logic pred_taken;
  logic [DISPATCH_WIDTH-1:0] exp_slots;
  pc_t exp_next;
  logic exp_fire_ctrl;

  logic [31:0] lcg_state;
  int check_errors;
  int load_errors;
  int test_start_errors;
  int tests_run;
  int tests_failed;

  frontend_top i_frontend_top (
    .clk                   (clk),
    .rst                   (rst),
    .fetch_enable_i        (fetch_enable),
    .s_axil_awaddr_i       (awaddr),
    .s_axil_awvalid_i      (awvalid),
    .s_axil_awready_o      (awready),
    .s_axil_wdata_i        (wdata),
    .s_axil_wstrb_i        (4'hf),
    .s_axil_wvalid_i       (wvalid),
    .s_axil_wready_o       (wready),
    .s_axil_bresp_o        (bresp),
    .s_axil_bvalid_o       (bvalid),
    .s_axil_bready_i       (1'b1),
    .s_axil_araddr_i       (araddr),
    .s_axil_arvalid_i      (arvalid),
    .s_axil_arready_o      (arready),
    .s_axil_rdata_o        (rdata),
    .s_axil_rresp_o        (rresp),
    .s_axil_rvalid_o       (rvalid),
    .s_axil_rready_i       (1'b1),
    .dispatch_valid_o      (dispatch_valid),
    .dispatch_ready_i      (dispatch_ready),
    .dispatch_pc0_o        (dispatch_pc0),
    .dispatch_pc1_o        (dispatch_pc1),
    .dispatch_instr0_o     (dispatch_instr0),
    .dispatch_instr1_o     (dispatch_instr1),
    .dispatch_slot_valid_o (dispatch_slot_valid),
    .resolve_valid_i       (resolve_valid),
    .resolve_taken_i       (resolve_taken),
    .speculative_o         (speculative)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired at %0d ns before the tests finished", $time);
    $display("TEST FAIL");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // riscv encoders taking byte offsets
  function automatic instr_t enc_branch(input pc_t off, input logic [31:0] r);
    return {off[12], off[10:5], r[24:15], 3'b000, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic instr_t enc_jal(input pc_t off, input logic [31:0] r);
    return {off[20], off[10:1], off[11], off[19:12], r[11:7], OPC_JAL};
  endfunction

  function automatic instr_t enc_jalr(input logic [31:0] r);
    return {r[31:15], 3'b000, r[11:7], OPC_JALR};
  endfunction

  function automatic instr_t enc_alu(input logic [31:0] r);
    return {r[31:7], 7'b001_0011};
  endfunction

  // expected dispatch view of the current pair
  always_comb begin
    idx0 = ref_pc[2 +: IMEM_ADDR_BITS];
    idx1 = idx0 + imem_addr_t'(1);
    ctrl0 = (img_kind[idx0] != CTRL_NONE);
    ctrl1 = (img_kind[idx1] != CTRL_NONE);
    if (ctrl0) begin
      first_kind = img_kind[idx0];
      first_target = ref_pc + img_off[idx0];
    end else begin
      first_kind = img_kind[idx1];
      first_target = ref_pc + 32'd4 + img_off[idx1];
    end
    pred_taken = (first_kind == CTRL_JAL) || ((first_kind == CTRL_BRANCH) && ref_counter[1]);
    if (!ref_spec) begin
      exp_slots = {!(ctrl0 && (pred_taken || ctrl1)), 1'b1};
      if (pred_taken) begin
        exp_next = first_target;
      end else if (ctrl0 && ctrl1) begin
        exp_next = ref_pc + 32'd4;
      end else begin
        exp_next = ref_pc + 32'd8;
      end
    end else begin
      exp_slots = {!ctrl0 && !ctrl1, !ctrl0};
      exp_next = ctrl0 ? ref_pc : (ctrl1 ? ref_pc + 32'd4 : ref_pc + 32'd8);
    end
    exp_fire_ctrl = (ctrl0 && exp_slots[0]) || (ctrl1 && exp_slots[1]);
  end

  always @(posedge clk) begin
    if (rst) begin
      ref_pc <= RESET_PC;
      ref_spec <= 1'b0;
      ref_counter <= 2'd1;
    end else begin
      if (fetch_enable && dispatch_ready) begin
        ref_pc <= exp_next;
      end
      // a resolution beats a new control fire
      if (resolve_valid) begin
        ref_spec <= 1'b0;
        if (resolve_taken && ref_counter != 2'd3) begin
          ref_counter <= ref_counter + 2'd1;
        end else if (!resolve_taken && ref_counter != 2'd0) begin
          ref_counter <= ref_counter - 2'd1;
        end
      end else if (fetch_enable && dispatch_ready && exp_fire_ctrl) begin
        ref_spec <= 1'b1;
      end
    end
  end

  task automatic flag_model_error(input string msg);
    check_errors++;
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
  endtask

  task automatic flag_bus_error(input string msg);
    load_errors++;
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
  endtask

  // outputs are settled halfway through the cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (fetch_enable) begin
        assert (dispatch_valid) else flag_model_error("dispatch valid low while enabled");
        assert (dispatch_pc0 == ref_pc && dispatch_pc1 == ref_pc + 32'd4)
          else flag_model_error($sformatf("pc0 %h, expected %h", dispatch_pc0, ref_pc));
        assert (dispatch_instr0 == image[idx0] && dispatch_instr1 == image[idx1])
          else flag_model_error($sformatf("instruction pair wrong at pc %h", ref_pc));
        assert (dispatch_slot_valid == exp_slots)
          else flag_model_error($sformatf("slot valid %b, expected %b at pc %h",
                                          dispatch_slot_valid, exp_slots, ref_pc));
      end else begin
        assert (!dispatch_valid && dispatch_slot_valid == '0)
          else flag_model_error("dispatch active while fetch is disabled");
      end
      assert (speculative == ref_spec)
        else flag_model_error($sformatf("speculative %b, expected %b", speculative, ref_spec));
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic axil_write(input imem_addr_t a, input instr_t data);
    int waited;
    waited = 0;
    @(posedge clk);
    awaddr <= xlen_t'({a, 2'b00});
    wdata <= data;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    @(negedge clk);
    while (!(awready && wready) && waited < HANDSHAKE_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!(awready && wready)) begin
      load_errors++;
      $display("write to word %0d was never accepted", a);
    end
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    @(negedge clk);
    assert (bvalid && bresp == AXIL_RESP_OKAY)
      else flag_bus_error($sformatf("no OKAY write response after word %0d", a));
  endtask

  task automatic axil_read_check(input imem_addr_t a);
    int waited;
    waited = 0;
    @(posedge clk);
    araddr <= xlen_t'({a, 2'b00});
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready && waited < HANDSHAKE_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!arready) begin
      load_errors++;
      $display("read of word %0d was never accepted", a);
    end
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    assert (rvalid && rresp == AXIL_RESP_OKAY && rdata == image[a])
      else flag_bus_error($sformatf("word %0d read %h, expected %h", a, rdata, image[a]));
  endtask

  task automatic build_program(input prog_t prog);
    imem_addr_t a;
    logic [31:0] r;
    logic [31:0] s;
    pc_t off;
    ctrl_kind_t k;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      a = imem_addr_t'(i);
      r = next_rand();
      s = next_rand();
      off = {{24{s[5]}}, s[5:0], 2'b00};
      if (off == '0) begin
        off = 32'd8;
      end
      case (prog)
        PROG_BRANCHES: k = (r[1:0] == 2'd0) ? CTRL_BRANCH : CTRL_NONE;
        PROG_JUMPS:    k = (r[2:0] == 3'd0) ? CTRL_JAL : ((r[2:0] == 3'd1) ? CTRL_JALR : CTRL_NONE);
        PROG_DENSE:    k = r[0] ? CTRL_BRANCH : CTRL_NONE;
        // adjacent branch pairs at words 4k and 4k+1
        PROG_PAIRS:    k = !a[1] ? CTRL_BRANCH : CTRL_NONE;
        default:       k = CTRL_NONE;
      endcase
      img_kind[a] = k;
      img_off[a] = off;
      case (k)
        CTRL_BRANCH: image[a] = enc_branch(off, r);
        CTRL_JAL:    image[a] = enc_jal(off, r);
        CTRL_JALR:   image[a] = enc_jalr(r);
        default:     image[a] = enc_alu(r);
      endcase
    end
  endtask

  task automatic start_program(input prog_t prog);
    build_program(prog);
    for (int i = 0; i < IMEM_WORDS; i++) begin
      axil_write(imem_addr_t'(i), image[i]);
    end
    apply_reset();
  endtask

  // back-end model with generated stalls and resolutions
  task automatic run_cycles(input int n, input logic stall, input logic [2:0] resolve_rate,
                            input logic [2:0] taken_bias);
    logic [31:0] r;
    repeat (n) begin
      @(posedge clk);
      r = next_rand();
      fetch_enable <= 1'b1;
      dispatch_ready <= stall ? (r[1:0] != 2'd0) : 1'b1;
      resolve_valid <= ref_spec && !resolve_valid && (r[4:2] < resolve_rate);
      resolve_taken <= (r[10:8] < taken_bias);
    end
    @(posedge clk);
    fetch_enable <= 1'b0;
    resolve_valid <= 1'b0;
    @(negedge clk);
  endtask

  task automatic close_test(input string name);
    int now_errors;
    now_errors = check_errors + load_errors;
    tests_run++;
    if (now_errors != test_start_errors) begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name,
               now_errors - test_start_errors);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    test_start_errors = now_errors;
  endtask

  initial begin
    imem_addr_t addrs [$];
    imem_addr_t a;
    rst = 1'b1;
    fetch_enable = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    dispatch_ready = 1'b0;
    resolve_valid = 1'b0;
    resolve_taken = 1'b0;
    lcg_state = 32'h1b72_e458;
    check_errors = 0;
    load_errors = 0;
    test_start_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    build_program(PROG_STRAIGHT);
    apply_reset();

    for (int i = 0; i < AXI_WORDS; i++) begin
      a = imem_addr_t'(next_rand() >> 24);
      image[a] = next_rand();
      addrs.push_back(a);
      axil_write(a, image[a]);
    end
    foreach (addrs[i]) begin
      axil_read_check(addrs[i]);
    end
    close_test("axi4-lite load and readback");

    start_program(PROG_STRAIGHT);
    run_cycles(RUN_LEN, 1'b1, 3'd0, 3'd0);
    close_test("straight-line fetch");

    // taken-heavy then never taken so the counter saturates at both ends
    start_program(PROG_BRANCHES);
    run_cycles(RUN_LEN, 1'b1, 3'd4, 3'd7);
    run_cycles(RUN_LEN, 1'b1, 3'd4, 3'd0);
    close_test("conditional prediction");

    start_program(PROG_JUMPS);
    run_cycles(RUN_LEN, 1'b1, 3'd6, 3'd4);
    close_test("jal and jalr");

    start_program(PROG_DENSE);
    run_cycles(RUN_LEN, 1'b0, 3'd1, 3'd2);
    close_test("speculation stall");

    start_program(PROG_PAIRS);
    run_cycles(RUN_LEN, 1'b1, 3'd4, 3'd1);
    close_test("two control instructions in a pair");

    $display("summary: %0d tests, %0d failed, %0d check errors, %0d bus errors",
             tests_run, tests_failed, check_errors, load_errors);
    if (tests_failed == 0 && check_errors + load_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
